// ==== Bender.yml ====
package:
  name: scope_capture

sources:
  - capture_pkg.sv
  - capture_memory.sv
  - trigger_detect.sv
  - capture_buffer.sv
  - scope_capture.sv
  - target: test
    files:
      - scope_capture_properties.sv
      - tb_scope_capture.sv

// ==== capture_buffer.sv ====
/*
 Triggered capture controller. Records accepted samples into the circular
 frame memory, keeps pre_count samples of history ahead of the trigger,
 fills the rest of the frame and then plays it out oldest first with
 out_last on the final beat. A skid register holds the memory output
 while the sink stalls. With enable low nothing is accepted or sent.
*/
`timescale 1ns/10ps

module capture_buffer (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 enable,
    input  capture_pkg::sample_t in_data,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic                 trigger,
    input  capture_pkg::addr_t   pre_count,
    output logic                 rearm,
    output logic                 full,
    output logic                 write_enable,
    output capture_pkg::addr_t   write_address,
    output capture_pkg::sample_t write_data,
    output capture_pkg::addr_t   read_address,
    input  capture_pkg::sample_t read_data,
    output capture_pkg::sample_t out_data,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 out_last
);

    capture_pkg::capture_state_t state;

    logic in_ready_q;
    logic accept;
    capture_pkg::addr_t wptr;
    capture_pkg::addr_t hist_cnt;
    capture_pkg::addr_t pre_q;
    capture_pkg::addr_t frame_start;
    logic [capture_pkg::addr_width:0] fill_cnt;
    logic [capture_pkg::addr_width:0] fill_next;
    logic frame_done;

    // In the playback pipeline rd_idx is on the address and s1 is the memory output
    logic [capture_pkg::addr_width:0] rd_idx;
    logic s1_vld;
    capture_pkg::addr_t s1_idx;
    logic s1_last;
    logic skid_vld;
    capture_pkg::sample_t skid_data;
    logic skid_last;
    logic show_valid;
    logic ready_eff;
    logic fire;
    logic skid_next;

    assign in_ready = in_ready_q && enable;
    assign accept = in_valid && in_ready;

    // Each accepted beat is written one cycle later at the next circular slot
    always_ff @(posedge clock) begin
        if (rst) begin
            write_enable <= 1'b0;
            wptr <= '0;
        end else begin
            write_enable <= accept;
            if (accept) begin
                wptr <= wptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        write_address <= wptr;
        write_data <= in_data;
    end

    // Frame samples so far. On the trigger this is the history plus the
    // trigger sample, plus a beat that may arrive in the same cycle
    always_comb begin
        if (state == capture_pkg::armed) begin
            fill_next = {1'b0, pre_q} + 1'b1 + accept;
        end else begin
            fill_next = fill_cnt + accept;
        end
    end

    assign frame_done = enable
        && (fill_next == (capture_pkg::addr_width + 1)'(capture_pkg::depth))
        && ((state == capture_pkg::armed && trigger)
            || (state == capture_pkg::acquiring && accept));

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= capture_pkg::arming;
            in_ready_q <= 1'b0;
            hist_cnt <= '0;
            fill_cnt <= '0;
            full <= 1'b0;
        end else begin
            full <= frame_done;
            if (enable) begin
                case (state)
                    capture_pkg::arming: begin
                        in_ready_q <= 1'b1;
                        if (accept) begin
                            hist_cnt <= hist_cnt + 1'b1;
                            // This beat has pre_q predecessors and may trigger
                            if (hist_cnt != '0 && hist_cnt == pre_q) begin
                                state <= capture_pkg::armed;
                            end
                        end
                    end
                    capture_pkg::armed: begin
                        if (trigger) begin
                            fill_cnt <= fill_next;
                            state <= capture_pkg::acquiring;
                        end
                    end
                    capture_pkg::acquiring: begin
                        fill_cnt <= fill_next;
                    end
                    capture_pkg::settling: begin
                        state <= capture_pkg::playing;
                    end
                    capture_pkg::playing: begin
                        if (rearm) begin
                            state <= capture_pkg::arming;
                            in_ready_q <= 1'b1;
                            hist_cnt <= '0;
                        end
                    end
                    default: begin
                        state <= capture_pkg::arming;
                    end
                endcase
                if (frame_done) begin
                    state <= capture_pkg::settling;
                    in_ready_q <= 1'b0;
                end
            end
        end
    end

    // The trigger arrives while write_address still holds the trigger sample
    always_ff @(posedge clock) begin
        if (state == capture_pkg::arming && hist_cnt == '0) begin
            pre_q <= pre_count;
        end
        if (enable && state == capture_pkg::armed && trigger) begin
            frame_start <= write_address - pre_q;
        end
    end

    assign read_address = frame_start + rd_idx[capture_pkg::addr_width-1:0];

    assign s1_last = (s1_idx == capture_pkg::addr_t'(capture_pkg::depth - 1));
    assign show_valid = skid_vld || s1_vld;
    assign ready_eff = out_ready && enable;
    assign fire = show_valid && ready_eff;
    // A stalled memory beat moves into the skid, a held skid beat stays
    assign skid_next = skid_vld ? !fire : (s1_vld && !ready_eff);

    assign out_valid = show_valid && enable;
    assign out_data = skid_vld ? skid_data : read_data;
    assign out_last = show_valid && (skid_vld ? skid_last : s1_last);
    assign rearm = fire && out_last;

    // While the skid is occupied the read address does not advance, so the
    // memory keeps presenting the sample right behind the skid
    always_ff @(posedge clock) begin
        if (rst) begin
            rd_idx <= '0;
            s1_vld <= 1'b0;
            skid_vld <= 1'b0;
        end else begin
            s1_vld <= (state == capture_pkg::playing) && !rd_idx[capture_pkg::addr_width];
            skid_vld <= skid_next;
            if (state != capture_pkg::playing) begin
                rd_idx <= '0;
            end else if (!skid_next && !rd_idx[capture_pkg::addr_width]) begin
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        s1_idx <= rd_idx[capture_pkg::addr_width-1:0];
        if (!skid_vld) begin
            skid_data <= read_data;
            skid_last <= s1_last;
        end
    end

endmodule

// ==== capture_memory.sv ====
/*
 Frame memory of the capture buffer. One synchronous write port and one
 read port whose data appears one cycle after the address. Every location
 is written by the recorder before playback reads it.
*/
`timescale 1ns/10ps

module capture_memory (
    input  logic                 clock,
    input  logic                 write_enable,
    input  capture_pkg::addr_t   write_address,
    input  capture_pkg::sample_t write_data,
    input  capture_pkg::addr_t   read_address,
    output capture_pkg::sample_t read_data
);

    capture_pkg::sample_t mem [capture_pkg::depth];

    // Write port
    always_ff @(posedge clock) begin
        if (write_enable) begin
            mem[write_address] <= write_data;
        end
    end

    // Registered read port
    // Old data is returned on a same-address collision
    always_ff @(posedge clock) begin
        read_data <= mem[read_address];
    end

endmodule

// ==== capture_pkg.sv ====
/*
 Common sizes, data types and the playback state encoding of the
 triggered capture buffer. RTL and testbench refer to every item here
 through scoped names such as capture_pkg::depth.
*/
package capture_pkg;

    // Width of one input sample
    localparam int sample_width = 16;

    // Frame memory address width; one frame fills the whole memory
    localparam int addr_width = 5;
    localparam int depth = 1 << addr_width;

    typedef logic [sample_width-1:0] sample_t;
    typedef logic [addr_width-1:0] addr_t;

    // Capture and playback sequence of the buffer
    typedef enum logic [2:0] {
        // Collecting the pre-trigger history
        arming,
        // Enough history, waiting for a crossing
        armed,
        // Filling the post-trigger part of the frame
        acquiring,
        // Read latency before the first beat
        settling,
        // Streaming the frame out
        playing
    } capture_state_t;

endpackage

// ==== scope_capture.sv ====
/*
 Top level of the triggered capture buffer. Samples come in on a
 valid/ready stream, a threshold crossing freezes a frame of depth
 samples around the trigger, and the frame leaves on a second stream
 with out_last on its final beat.
*/
`timescale 1ns/10ps

module scope_capture (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 enable,
    input  capture_pkg::sample_t in_data,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  capture_pkg::sample_t threshold,
    input  capture_pkg::addr_t   pre_count,
    output capture_pkg::sample_t out_data,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 out_last,
    output logic                 full
);

    logic sample_strobe;
    logic trigger;
    logic rearm;
    logic write_enable;
    capture_pkg::addr_t write_address;
    capture_pkg::sample_t write_data;
    capture_pkg::addr_t read_address;
    capture_pkg::sample_t read_data;

    // Transferred input beat
    assign sample_strobe = in_valid && in_ready;

    trigger_detect u_trigger (
        .clock         (clock),
        .rst           (rst),
        .sample_strobe (sample_strobe),
        .sample        (in_data),
        .threshold     (threshold),
        .rearm         (rearm),
        .trigger       (trigger)
    );

    capture_buffer u_buffer (
        .clock         (clock),
        .rst           (rst),
        .enable        (enable),
        .in_data       (in_data),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .trigger       (trigger),
        .pre_count     (pre_count),
        .rearm         (rearm),
        .full          (full),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data),
        .read_address  (read_address),
        .read_data     (read_data),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_last      (out_last)
    );

    capture_memory u_memory (
        .clock         (clock),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data),
        .read_address  (read_address),
        .read_data     (read_data)
    );

endmodule

// ==== scope_capture_properties.sv ====
/*
 Concurrent checks on the stream handshakes of the capture buffer. The
 module is bound into every capture_buffer instance and keeps a count of
 assertion failures next to the $error report.
*/
`timescale 1ns/10ps

module scope_capture_properties (
    input logic                 clock,
    input logic                 rst,
    input logic                 in_ready,
    input logic                 full,
    input capture_pkg::sample_t out_data,
    input logic                 out_valid,
    input logic                 out_ready,
    input logic                 out_last
);

    int failures = 0;

    // A stalled output beat keeps its data and its last flag
    hold_while_stalled: assert property (@(posedge clock) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_data) && $stable(out_last))
        else begin
            failures++;
            $error("out_data or out_last changed while the beat was stalled");
        end

    // Recording and playback never overlap
    never_both_active: assert property (@(posedge clock) disable iff (rst)
        !(in_ready && out_valid))
        else begin
            failures++;
            $error("in_ready and out_valid were high together");
        end

    full_single_pulse: assert property (@(posedge clock) disable iff (rst)
        full |=> !full)
        else begin
            failures++;
            $error("full stayed high for more than one cycle");
        end

endmodule

bind capture_buffer scope_capture_properties u_properties (
    .clock     (clock),
    .rst       (rst),
    .in_ready  (in_ready),
    .full      (full),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_last)
);

// ==== tb_scope_capture.sv ====
/*
 Directed testbench of the triggered capture buffer. A driver feeds sample
 sequences, a collector gathers each played frame and a small model rebuilds
 the expected frame from the samples the DUT really accepted. Compile with
 verilog.f and run tb_scope_capture as the top.
*/
`timescale 1ns/10ps

module tb_scope_capture;

    localparam int depth = capture_pkg::depth;
    localparam int timeout = 200;

    logic clock;
    logic rst;
    logic enable;
    capture_pkg::sample_t in_data;
    logic in_valid;
    logic in_ready;
    capture_pkg::sample_t threshold;
    capture_pkg::addr_t pre_count;
    capture_pkg::sample_t out_data;
    logic out_valid;
    logic out_ready;
    logic out_last;
    logic full;

    capture_pkg::sample_t stim [256];
    capture_pkg::sample_t accepted [$];
    capture_pkg::sample_t got [$];
    int errors;
    int frames;
    int full_count;
    logic frame_full;
    integer seed;

    scope_capture UUT (
        .clock     (clock),
        .rst       (rst),
        .enable    (enable),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .threshold (threshold),
        .pre_count (pre_count),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last),
        .full      (full)
    );

    always #4 clock = ~clock;

    // Mid-cycle view of the input handshake, the full pulse and the freeze
    always @(negedge clock) begin
        if (!rst) begin
            if (in_valid && in_ready) begin
                accepted.push_back(in_data);
            end
            if (full) begin
                full_count++;
                frame_full = 1'b1;
            end
            if (!enable && (in_ready || out_valid)) begin
                errors++;
                $display("Handshake active while enable was low at time %0t", $time);
            end
        end
    end

    function automatic void fill_ramp(input int start, input int step);
        int i;
        for (i = 0; i < 256; i++) begin
            stim[i] = capture_pkg::sample_t'(start + i * step);
        end
    endfunction

    // Offers stim in order until the frame is full or the list runs out
    task automatic drive_samples(input int count);
        int idx;
        int stall;
        logic took;
        idx = 0;
        stall = 0;
        @(posedge clock);
        in_valid <= 1'b1;
        in_data <= stim[0];
        while (idx < count && !frame_full && stall < timeout) begin
            @(negedge clock);
            took = in_valid && in_ready;
            @(posedge clock);
            if (took) begin
                idx++;
                stall = 0;
                in_data <= stim[idx % 256];
            end else begin
                stall++;
            end
        end
        in_valid <= 1'b0;
        if (stall >= timeout) begin
            errors++;
            $display("Timeout waiting for in_ready at time %0t", $time);
        end
    endtask

    task automatic collect_frame(input bit random_ready);
        int idle;
        logic [31:0] r;
        logic done;
        idle = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clock);
            r = $random(seed);
            out_ready <= random_ready ? r[0] : 1'b1;
            @(negedge clock);
            if (out_valid && out_ready) begin
                got.push_back(out_data);
                idle = 0;
                if (out_last !== (got.size() == depth)) begin
                    errors++;
                    $display("mismatch at time %0t: out_last got %b expected %b",
                             $time, out_last, got.size() == depth);
                end
                done = out_last || (got.size() >= depth);
            end else begin
                idle++;
                if (idle >= timeout) begin
                    errors++;
                    $display("Timeout waiting for an output beat at time %0t", $time);
                    done = 1'b1;
                end
            end
        end
    endtask

    // Drops enable for a while once the given number of beats has left
    task automatic freeze_output(input int after_beats);
        int cycles;
        cycles = 0;
        if (after_beats > 0) begin
            while (got.size() < after_beats && cycles < timeout) begin
                @(negedge clock);
                cycles++;
            end
            if (cycles >= timeout) begin
                errors++;
                $display("Playback never reached the freeze point at time %0t", $time);
            end
            @(posedge clock);
            enable <= 1'b0;
            repeat (8) @(posedge clock);
            enable <= 1'b1;
        end
    endtask

    // The trigger is the first crossing with at least pre samples before it
    task automatic check_frame(input int pre, input capture_pkg::sample_t thr);
        int t;
        int start;
        int i;
        t = pre;
        while (t < accepted.size() && !(accepted[t] > thr && accepted[t - 1] <= thr)) begin
            t++;
        end
        start = t - pre;
        frames++;
        if (start + depth > accepted.size()) begin
            errors++;
            $display("No complete frame among the accepted samples at time %0t", $time);
        end else if (got.size() != depth) begin
            errors++;
            $display("mismatch at time %0t: frame length got %0d expected %0d",
                     $time, got.size(), depth);
        end else begin
            for (i = 0; i < depth; i++) begin
                if (got[i] !== accepted[start + i]) begin
                    errors++;
                    $display("mismatch at time %0t: out_data[%0d] got %h expected %h",
                             $time, i, got[i], accepted[start + i]);
                end
            end
        end
        if (full_count != 1) begin
            errors++;
            $display("mismatch at time %0t: full pulses got %0d expected 1", $time, full_count);
        end
    endtask

    task automatic run_frame(input int pre, input int thr, input int count,
                             input bit random_ready, input int freeze_after);
        @(posedge clock);
        pre_count <= capture_pkg::addr_t'(pre);
        threshold <= capture_pkg::sample_t'(thr);
        accepted.delete();
        got.delete();
        frame_full = 1'b0;
        full_count = 0;
        fork
            drive_samples(count);
            collect_frame(random_ready);
            freeze_output(freeze_after);
        join
        check_frame(pre, capture_pkg::sample_t'(thr));
    endtask

    task automatic basic_frame();
        fill_ramp(0, 50);
        run_frame(8, 1000, 80, 1'b0, 0);
    endtask

    task automatic pre_count_range();
        fill_ramp(0, 50);
        run_frame(1, 1000, 80, 1'b0, 0);
        run_frame(depth - 2, 2000, 80, 1'b0, 0);
    endtask

    // A crossing at sample 3 comes before ten samples of history exist
    task automatic early_crossing();
        int i;
        for (i = 0; i < 256; i++) begin
            if (i < 3) begin
                stim[i] = 16'd100;
            end else if (i < 6) begin
                stim[i] = 16'd900;
            end else if (i < 25) begin
                stim[i] = 16'd200;
            end else begin
                stim[i] = capture_pkg::sample_t'(800 + i);
            end
        end
        run_frame(10, 500, 80, 1'b0, 0);
    endtask

    task automatic back_pressure();
        fill_ramp(7, 40);
        run_frame(12, 1500, 80, 1'b1, 0);
    endtask

    task automatic rearm_back_to_back();
        int cycles;
        fill_ramp(0, 30);
        run_frame(5, 600, 80, 1'b0, 0);
        cycles = 0;
        while (!in_ready && cycles < 4) begin
            @(negedge clock);
            cycles++;
        end
        if (!in_ready) begin
            errors++;
            $display("in_ready did not return after the last beat at time %0t", $time);
        end
        fill_ramp(1000, 100);
        run_frame(20, 3000, 80, 1'b0, 0);
    endtask

    task automatic enable_freeze();
        fill_ramp(0, 25);
        run_frame(16, 1200, 100, 1'b0, 10);
    endtask

    initial begin
        clock = 1'b0;
        rst = 1'b1;
        enable = 1'b1;
        in_data = '0;
        in_valid = 1'b0;
        threshold = '0;
        pre_count = 1;
        out_ready = 1'b0;
        errors = 0;
        frames = 0;
        full_count = 0;
        frame_full = 1'b0;
        seed = 32'h6ffd_c29e;
        repeat (3) @(posedge clock);
        rst <= 1'b0;
        basic_frame();
        pre_count_range();
        early_crossing();
        back_pressure();
        rearm_back_to_back();
        enable_freeze();
        repeat (4) @(posedge clock);
        errors += UUT.u_buffer.u_properties.failures;
        $display("Frames checked: %0d, errors: %0d", frames, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== trigger_detect.sv ====
/*
 Rising-edge threshold trigger. Watches every accepted sample and pulses
 trigger for one cycle, one cycle after a sample above the threshold that
 follows a sample at or below it. The first sample after reset or rearm
 only primes the history.
*/
`timescale 1ns/10ps

module trigger_detect (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 sample_strobe,
    input  capture_pkg::sample_t sample,
    input  capture_pkg::sample_t threshold,
    input  logic                 rearm,
    output logic                 trigger
);

    capture_pkg::sample_t prev_sample;
    capture_pkg::sample_t thr_q;
    logic has_prev;

    always_ff @(posedge clock) begin
        if (rst || rearm) begin
            has_prev <= 1'b0;
            prev_sample <= '0;
            trigger <= 1'b0;
        end else begin
            trigger <= sample_strobe && has_prev && (sample > thr_q) && (prev_sample <= thr_q);
            if (sample_strobe) begin
                has_prev <= 1'b1;
                prev_sample <= sample;
            end
        end
    end

    // The threshold is taken while no sample of the new frame has arrived,
    // so it stays constant for the whole acquisition
    always_ff @(posedge clock) begin
        if (!has_prev) begin
            thr_q <= threshold;
        end
    end

endmodule

// ==== verilog.f ====
capture_pkg.sv
capture_memory.sv
trigger_detect.sv
capture_buffer.sv
scope_capture.sv
scope_capture_properties.sv
tb_scope_capture.sv
